// File: flash_ctrl_pkg.sv
package flash_ctrl_pkg;

  // bus and flash geometry
  localparam int WB_DW      = 16;  // wishbone data width
  localparam int WB_AW      = 16;  // wishbone address width
  localparam int FM_AW      = 17;  // flash word address width
  localparam int PAGE_WORDS = 64;  // words per flash page
  localparam int REG_SPACE  = 64;  // first bus address mapped to flash

  // control registers live at bus addresses 0..63
  typedef enum logic [5:0] {
    REG_FLASH_STATUS = 6'd0,  // busy and last transfer status
    REG_PAGE_STATUS  = 6'd1,  // write latches page, read fetches program count
    REG_DIRTY_PAGE   = 6'd2,  // dirty page index or all ones when clean
    REG_DIRTY_SYNC   = 6'd3   // write programs the dirty page back
  } reg_offset_e;

  // bus side FSM
  typedef enum logic {
    WB_IDLE,  // waiting for a new cycle
    WB_WAIT   // flash transfer in flight
  } wb_state_e;

  // flash side FSM
  typedef enum logic [1:0] {
    FM_IDLE,
    FM_READ,     // also used for the page status transfer
    FM_WRITE,
    FM_PROGRAM   // write-back of the dirty page
  } fm_state_e;

  // source of wb_dat_o
  typedef enum logic [1:0] {
    DOUT_FLASH,   // registered flash read data
    DOUT_STATUS,  // busy and status bits
    DOUT_DIRTY,   // dirty page index
    DOUT_ZERO
  } dout_sel_e;

  // status codes returned by the flash macro
  localparam logic [1:0] FM_OK        = 2'b00;
  localparam logic [1:0] FM_RANGE_ERR = 2'b01;  // page index beyond the array

endpackage

// File: flashmem_controller.sv
`timescale 1ns/10ps

module flashmem_controller import flash_ctrl_pkg::*; (
  input  logic             wb_clk_i,
  input  logic             wb_rst_i,
  input  logic             wb_cyc_i,
  input  logic             wb_stb_i,
  input  logic             wb_we_i,
  input  logic [WB_AW-1:0] wb_adr_i,
  input  logic [WB_DW-1:0] wb_dat_i,
  output logic [WB_DW-1:0] wb_dat_o,
  output logic             wb_ack_o,
  output logic [FM_AW-1:0] fm_addr_o,
  output logic [WB_DW-1:0] fm_wd_o,
  output logic             fm_ren_o,
  output logic             fm_wen_o,
  output logic             fm_program_o,
  output logic             fm_pagestatus_o,
  input  logic [WB_DW-1:0] fm_rd_i,
  input  logic             fm_busy_i,
  input  logic [1:0]       fm_status_i
);

  localparam int WORD_W    = $clog2(PAGE_WORDS);  // word bits within a page
  localparam int PAGE_W    = WB_AW - WORD_W;      // page bits seen from the bus
  localparam int FM_PAGE_W = FM_AW - WORD_W;      // page bits of the flash address
  localparam int OFF_W     = $bits(reg_offset_e);

  // bus decode
  logic              fm_sel;      // address falls in flash space
  logic [WB_AW-1:0]  flash_addr;  // word address inside the flash
  logic [PAGE_W-1:0] page_index;  // page of the current bus access
  reg_offset_e       reg_off;
  logic              wb_take;     // a new cycle is accepted
  logic              status_wr;   // write to the page status register

  // bus FSM
  wb_state_e         wb_state;
  dout_sel_e         dout_sel;
  logic              reg_ack;     // ack for plain register accesses

  // one-cycle requests from the bus FSM to the flash FSM
  logic              req_read;
  logic              req_write;
  logic              req_status;
  logic              req_sync;
  logic              op_done;     // flash transfer finished, acks the bus

  // flash FSM
  fm_state_e         fm_state;
  logic              dirty;         // buffer holds unprogrammed data
  logic [PAGE_W-1:0] buf_index;     // page currently held in the buffer
  logic [FM_PAGE_W-1:0] status_page;  // page picked for the status read
  logic [2:0]        flash_status;  // status of the last transfer
  logic [WB_DW-1:0]  rd_data;
  logic              wait_cycle;    // busy is not valid yet after a strobe
  logic              status_op;     // current read is a page status read
  logic              pend_write;    // after the program continue with a write
  logic              pend_sync;     // program was requested by a sync
  logic              fm_ready;

  assign fm_sel     = (wb_adr_i >= REG_SPACE);
  assign flash_addr = wb_adr_i - WB_AW'(REG_SPACE);
  assign page_index = flash_addr[WB_AW-1:WORD_W];
  assign reg_off    = reg_offset_e'(wb_adr_i[OFF_W-1:0]);
  assign wb_take    = wb_cyc_i & wb_stb_i & ~wb_ack_o;
  assign status_wr  = (wb_state == WB_IDLE) && wb_take && !fm_sel && wb_we_i &&
                      (reg_off == REG_PAGE_STATUS);

  assign wb_ack_o = reg_ack | op_done;
  assign fm_wd_o  = wb_dat_i;  // master holds data for the whole cycle
  assign fm_ready = ~fm_busy_i & ~wait_cycle;

  always_comb begin
    case (dout_sel)
      DOUT_FLASH:  wb_dat_o = rd_data;
      DOUT_STATUS: wb_dat_o = WB_DW'({fm_busy_i, 5'b0, flash_status});  // busy in bit 8
      DOUT_DIRTY:  wb_dat_o = dirty ? WB_DW'(buf_index) : '1;
      default:     wb_dat_o = '0;
    endcase
  end

  // flash address follows the operation in progress
  always_comb begin
    if (fm_state == FM_PROGRAM) begin
      fm_addr_o = FM_AW'({buf_index, {WORD_W{1'b0}}});
    end else if (status_op) begin
      fm_addr_o = {status_page, {WORD_W{1'b0}}};
    end else begin
      fm_addr_o = FM_AW'(flash_addr);
    end
  end

  // bus FSM: register decode and request launch
  always_ff @(posedge wb_clk_i) begin
    reg_ack    <= 1'b0;
    req_read   <= 1'b0;
    req_write  <= 1'b0;
    req_status <= 1'b0;
    req_sync   <= 1'b0;

    if (wb_rst_i) begin
      wb_state <= WB_IDLE;
      dout_sel <= DOUT_ZERO;
    end else begin
      case (wb_state)
        WB_IDLE: begin
          if (wb_take && fm_sel) begin
            req_write <= wb_we_i;
            req_read  <= ~wb_we_i;
            dout_sel  <= DOUT_FLASH;
            wb_state  <= WB_WAIT;
          end else if (wb_take) begin
            case (reg_off)
              REG_FLASH_STATUS: begin
                dout_sel <= DOUT_STATUS;
                reg_ack  <= 1'b1;
              end
              REG_PAGE_STATUS: begin
                if (wb_we_i) begin
                  reg_ack <= 1'b1;  // page latched below
                end else begin
                  dout_sel   <= DOUT_FLASH;
                  req_status <= 1'b1;
                  wb_state   <= WB_WAIT;
                end
              end
              REG_DIRTY_PAGE: begin
                dout_sel <= DOUT_DIRTY;
                reg_ack  <= 1'b1;
              end
              REG_DIRTY_SYNC: begin
                dout_sel <= DOUT_ZERO;
                if (wb_we_i) begin
                  req_sync <= 1'b1;
                  wb_state <= WB_WAIT;
                end else begin
                  reg_ack <= 1'b1;
                end
              end
              default: begin
                dout_sel <= DOUT_ZERO;  // unmapped offsets read zero
                reg_ack  <= 1'b1;
              end
            endcase
          end
        end
        WB_WAIT: begin
          if (op_done) begin
            wb_state <= WB_IDLE;
          end
        end
      endcase
    end
  end

  always_ff @(posedge wb_clk_i) begin
    if (status_wr) begin
      status_page <= wb_dat_i[FM_PAGE_W-1:0];
    end
  end

  always_ff @(posedge wb_clk_i) begin
    if ((fm_state == FM_READ) && fm_ready) begin
      rd_data <= fm_rd_i;
    end
  end

  // flash FSM: sequencing and dirty page tracking
  always_ff @(posedge wb_clk_i) begin
    wait_cycle      <= 1'b0;
    fm_ren_o        <= 1'b0;
    fm_wen_o        <= 1'b0;
    fm_program_o    <= 1'b0;
    fm_pagestatus_o <= 1'b0;
    op_done         <= 1'b0;

    if (wb_rst_i) begin
      fm_state     <= FM_IDLE;
      dirty        <= 1'b0;
      buf_index    <= '0;
      flash_status <= 3'b111;
      status_op    <= 1'b0;
      pend_write   <= 1'b0;
      pend_sync    <= 1'b0;
    end else begin
      case (fm_state)
        FM_IDLE: begin
          wait_cycle <= 1'b1;  // covers the cycle after any strobe issued here
          if (req_status) begin
            status_op       <= 1'b1;
            fm_pagestatus_o <= 1'b1;
            fm_state        <= FM_READ;
          end else if (req_sync) begin
            status_op <= 1'b0;
            if (dirty) begin
              pend_sync    <= 1'b1;
              fm_program_o <= 1'b1;
              fm_state     <= FM_PROGRAM;
            end else begin
              op_done <= 1'b1;  // clean buffer, nothing to write back
            end
          end else if (req_read || req_write) begin
            status_op <= 1'b0;
            if (dirty && (buf_index != page_index)) begin
              // access leaves the dirty page, program it first
              pend_sync    <= 1'b0;
              pend_write   <= req_write;
              fm_program_o <= 1'b1;
              fm_state     <= FM_PROGRAM;
            end else if (req_write) begin
              fm_wen_o <= 1'b1;
              fm_state <= FM_WRITE;
            end else begin
              fm_ren_o <= 1'b1;
              fm_state <= FM_READ;
            end
          end
        end
        FM_PROGRAM: begin
          if (fm_ready) begin
            wait_cycle   <= 1'b1;
            flash_status <= {1'b0, fm_status_i};
            if (fm_status_i == FM_OK) begin
              dirty <= 1'b0;
            end
            if (pend_sync) begin
              op_done  <= 1'b1;
              fm_state <= FM_IDLE;
            end else if (pend_write) begin
              fm_wen_o <= 1'b1;
              fm_state <= FM_WRITE;
            end else begin
              fm_ren_o <= 1'b1;
              fm_state <= FM_READ;
            end
          end
        end
        FM_READ: begin
          if (fm_ready) begin
            flash_status <= {1'b0, fm_status_i};
            op_done      <= 1'b1;
            fm_state     <= FM_IDLE;
            if ((fm_status_i == FM_OK) && !status_op) begin
              buf_index <= page_index;  // read reloads the buffer
            end
          end
        end
        FM_WRITE: begin
          if (fm_ready) begin
            flash_status <= {1'b0, fm_status_i};
            op_done      <= 1'b1;
            fm_state     <= FM_IDLE;
            if (fm_status_i == FM_OK) begin
              dirty     <= 1'b1;
              buf_index <= page_index;
            end
          end
        end
      endcase
    end
  end

endmodule

// File: flash_emulator.sv
`timescale 1ns/10ps

module flash_emulator import flash_ctrl_pkg::*; #(
  parameter int PAGE_COUNT  = 16,
  parameter int OP_CYCLES   = 3,
  parameter int PROG_CYCLES = 12
) (
  input  logic             wb_clk_i,
  input  logic             wb_rst_i,
  input  logic [FM_AW-1:0] fm_addr_i,
  input  logic [WB_DW-1:0] fm_wd_i,
  input  logic             fm_ren_i,
  input  logic             fm_wen_i,
  input  logic             fm_program_i,
  input  logic             fm_pagestatus_i,
  output logic [WB_DW-1:0] fm_rd_o,
  output logic             fm_busy_o,
  output logic [1:0]       fm_status_o
);

  localparam int WORD_W  = $clog2(PAGE_WORDS);
  localparam int PAGE_W  = FM_AW - WORD_W;
  localparam int IDX_W   = (PAGE_COUNT > 1) ? $clog2(PAGE_COUNT) : 1;
  localparam int MAX_CYC = (PROG_CYCLES > OP_CYCLES) ? PROG_CYCLES : OP_CYCLES;
  localparam int CNT_W   = $clog2(MAX_CYC + 1);

  logic [WB_DW-1:0]  flash_array [PAGE_COUNT][PAGE_WORDS];  // programmed contents
  logic [WB_DW-1:0]  prog_count [PAGE_COUNT];  // programs per page
  logic [WB_DW-1:0]  page_buf [PAGE_WORDS];
  logic [PAGE_W-1:0] buf_page;   // page tag of the buffer
  logic              buf_valid;  // buffer loaded since reset
  logic [CNT_W-1:0]  busy_cnt;

  logic [PAGE_W-1:0] page;
  logic [WORD_W-1:0] word;
  logic [IDX_W-1:0]  idx;         // array row, valid only when in range
  logic              in_range;
  logic              buf_hit;
  logic              any_strobe;

  assign page       = fm_addr_i[FM_AW-1:WORD_W];
  assign word       = fm_addr_i[WORD_W-1:0];
  assign idx        = page[IDX_W-1:0];
  assign in_range   = (page < PAGE_COUNT);
  assign buf_hit    = buf_valid && (buf_page == page);
  assign any_strobe = fm_ren_i | fm_wen_i | fm_program_i | fm_pagestatus_i;

  assign fm_busy_o = (busy_cnt != '0);  // high from the cycle after a strobe

  // array, counters, buffer tag, busy timer and status
  always_ff @(posedge wb_clk_i) begin
    if (wb_rst_i) begin
      busy_cnt    <= '0;
      fm_status_o <= FM_OK;
      buf_valid   <= 1'b0;
      buf_page    <= '0;
      for (int p = 0; p < PAGE_COUNT; p++) begin
        prog_count[p] <= '0;
        for (int w = 0; w < PAGE_WORDS; w++) begin
          flash_array[p][w] <= '0;
        end
      end
    end else begin
      if (busy_cnt != '0) begin
        busy_cnt <= busy_cnt - 1'b1;
      end
      if (any_strobe) begin
        busy_cnt    <= fm_program_i ? CNT_W'(PROG_CYCLES) : CNT_W'(OP_CYCLES);
        fm_status_o <= in_range ? FM_OK : FM_RANGE_ERR;
      end
      if (any_strobe && in_range) begin
        if (fm_program_i) begin
          for (int w = 0; w < PAGE_WORDS; w++) begin
            flash_array[idx][w] <= page_buf[w];
          end
          prog_count[idx] <= prog_count[idx] + 1'b1;
        end else if (fm_wen_i || fm_ren_i) begin
          buf_valid <= 1'b1;  // buffer now holds this page
          buf_page  <= page;
        end
      end
    end
  end

  // page buffer contents and read data
  always_ff @(posedge wb_clk_i) begin
    if (in_range && !fm_program_i) begin
      if (fm_wen_i) begin
        if (!buf_hit) begin
          for (int w = 0; w < PAGE_WORDS; w++) begin
            page_buf[w] <= flash_array[idx][w];  // reload before the store
          end
        end
        page_buf[word] <= fm_wd_i;  // later assignment wins over the reload
      end else if (fm_ren_i) begin
        if (buf_hit) begin
          fm_rd_o <= page_buf[word];
        end else begin
          fm_rd_o <= flash_array[idx][word];
          for (int w = 0; w < PAGE_WORDS; w++) begin
            page_buf[w] <= flash_array[idx][w];
          end
        end
      end else if (fm_pagestatus_i) begin
        fm_rd_o <= prog_count[idx];
      end
    end
  end

endmodule

// File: flash_subsystem.sv
`timescale 1ns/10ps

module flash_subsystem import flash_ctrl_pkg::*; #(
  parameter int PAGE_COUNT  = 16,  // implemented flash pages
  parameter int OP_CYCLES   = 3,   // busy length of a read or write
  parameter int PROG_CYCLES = 12   // busy length of a page program
) (
  input  logic             wb_clk_i,
  input  logic             wb_rst_i,
  input  logic             wb_cyc_i,
  input  logic             wb_stb_i,
  input  logic             wb_we_i,
  input  logic [WB_AW-1:0] wb_adr_i,
  input  logic [WB_DW-1:0] wb_dat_i,
  output logic [WB_DW-1:0] wb_dat_o,
  output logic             wb_ack_o
);

  // controller to flash macro
  logic [FM_AW-1:0] fm_addr;
  logic [WB_DW-1:0] fm_wd;
  logic             fm_ren;
  logic             fm_wen;
  logic             fm_program;
  logic             fm_pagestatus;

  // flash macro back to controller
  logic [WB_DW-1:0] fm_rd;
  logic             fm_busy;
  logic [1:0]       fm_status;

  flashmem_controller flashmem_controller_inst (
    .wb_clk_i        (wb_clk_i),
    .wb_rst_i        (wb_rst_i),
    .wb_cyc_i        (wb_cyc_i),
    .wb_stb_i        (wb_stb_i),
    .wb_we_i         (wb_we_i),
    .wb_adr_i        (wb_adr_i),
    .wb_dat_i        (wb_dat_i),
    .wb_dat_o        (wb_dat_o),
    .wb_ack_o        (wb_ack_o),
    .fm_addr_o       (fm_addr),
    .fm_wd_o         (fm_wd),
    .fm_ren_o        (fm_ren),
    .fm_wen_o        (fm_wen),
    .fm_program_o    (fm_program),
    .fm_pagestatus_o (fm_pagestatus),
    .fm_rd_i         (fm_rd),
    .fm_busy_i       (fm_busy),
    .fm_status_i     (fm_status)
  );

  flash_emulator #(
    .PAGE_COUNT  (PAGE_COUNT),
    .OP_CYCLES   (OP_CYCLES),
    .PROG_CYCLES (PROG_CYCLES)
  ) flash_emulator_inst (
    .wb_clk_i        (wb_clk_i),
    .wb_rst_i        (wb_rst_i),
    .fm_addr_i       (fm_addr),
    .fm_wd_i         (fm_wd),
    .fm_ren_i        (fm_ren),
    .fm_wen_i        (fm_wen),
    .fm_program_i    (fm_program),
    .fm_pagestatus_i (fm_pagestatus),
    .fm_rd_o         (fm_rd),
    .fm_busy_o       (fm_busy),
    .fm_status_o     (fm_status)
  );

endmodule

// File: tb_clock_gen.sv
`timescale 1ns/10ps

module tb_clock_gen #(
  parameter int PERIOD_NS    = 10,
  parameter int RESET_CYCLES = 3
) (
  output logic clk_o,
  output logic rst_o  // synchronous, active high
);

  initial begin
    clk_o = 1'b0;
    forever #(PERIOD_NS / 2) clk_o = ~clk_o;
  end

  initial begin
    rst_o = 1'b1;
    repeat (RESET_CYCLES) @(posedge clk_o);
    #1 rst_o = 1'b0;  // released just after the edge like other inputs
  end

endmodule

// File: tb_flash_subsystem.sv
`timescale 1ns/10ps

module tb_flash_subsystem import flash_ctrl_pkg::*; ();

  localparam int PAGE_COUNT   = 16;
  localparam int OP_CYCLES    = 3;
  localparam int PROG_CYCLES  = 12;
  localparam int RESET_CYCLES = 3;
  localparam int T1_WRITES    = 12;  // random writes into the buffered page
  localparam int T2_READS     = 8;
  localparam int T3_WRITES    = 4;
  localparam int NUM_ACCESSES = 2 + (2 * T1_WRITES + 1) + (6 + T2_READS) +
                                (2 * T3_WRITES + 5) + 10 + 8;
  localparam int WATCHDOG_CYCLES = RESET_CYCLES + 200 * NUM_ACCESSES;
  localparam logic [WB_AW-1:0] ADR_STATUS = WB_AW'(REG_FLASH_STATUS);
  localparam logic [WB_AW-1:0] ADR_PSTAT  = WB_AW'(REG_PAGE_STATUS);
  localparam logic [WB_AW-1:0] ADR_DIRTY  = WB_AW'(REG_DIRTY_PAGE);
  localparam logic [WB_AW-1:0] ADR_SYNC   = WB_AW'(REG_DIRTY_SYNC);

  logic wb_clk, wb_rst, wb_cyc, wb_stb, wb_we, wb_ack;
  logic [WB_AW-1:0] wb_adr;
  logic [WB_DW-1:0] wb_wdat, wb_rdat;

  // shadow copy of the flash, its buffer and the controller status
  logic [WB_DW-1:0] shadow_array [PAGE_COUNT][PAGE_WORDS];
  logic [WB_DW-1:0] shadow_buf [PAGE_WORDS];
  logic [WB_DW-1:0] shadow_prog [PAGE_COUNT];  // program count per page
  int               shadow_buf_page, shadow_status_page;
  logic             shadow_buf_valid, shadow_dirty;
  logic [2:0]       shadow_status;

  logic [WB_DW-1:0] exp_q [$];
  logic [WB_AW-1:0] addr_q [$];
  logic [WB_DW-1:0] exp_val;
  logic [WB_AW-1:0] exp_addr, t1_addr [T1_WRITES], t3_addr [T3_WRITES];
  logic             rd_active;  // a read cycle is on the bus
  int pass_count, fail_count, pass_start, fail_start, i;
  int status_pages [5] = '{3, 7, 9, 0, 15};

  tb_clock_gen #(.PERIOD_NS(10), .RESET_CYCLES(RESET_CYCLES)) tb_clock_gen_inst (
    .clk_o (wb_clk),
    .rst_o (wb_rst)
  );

  flash_subsystem #(
    .PAGE_COUNT  (PAGE_COUNT),
    .OP_CYCLES   (OP_CYCLES),
    .PROG_CYCLES (PROG_CYCLES)
  ) flash_subsystem_inst (
    .wb_clk_i (wb_clk),
    .wb_rst_i (wb_rst),
    .wb_cyc_i (wb_cyc),
    .wb_stb_i (wb_stb),
    .wb_we_i  (wb_we),
    .wb_adr_i (wb_adr),
    .wb_dat_i (wb_wdat),
    .wb_dat_o (wb_rdat),
    .wb_ack_o (wb_ack)
  );

  function automatic logic [WB_AW-1:0] word_address(input int page, input int word);
    return WB_AW'(REG_SPACE + page * PAGE_WORDS + word);
  endfunction

  // write-back of the dirty buffer into its array page
  function automatic void program_shadow();
    foreach (shadow_buf[w]) shadow_array[shadow_buf_page][w] = shadow_buf[w];
    shadow_prog[shadow_buf_page] = shadow_prog[shadow_buf_page] + 1'b1;
    shadow_dirty  = 1'b0;
    shadow_status = 3'b000;
  endfunction

  function automatic void update_shadow(input logic we, input logic [WB_AW-1:0] addr,
                                        input logic [WB_DW-1:0] data);
    int page;
    int word;
    if (addr < REG_SPACE) begin
      if (we && addr[5:0] == REG_PAGE_STATUS) begin
        shadow_status_page = int'(data[10:0]);  // page field of the flash address
      end else if (addr[5:0] == REG_PAGE_STATUS) begin
        shadow_status = (shadow_status_page < PAGE_COUNT) ? 3'b000 : 3'b001;
      end else if (we && addr[5:0] == REG_DIRTY_SYNC && shadow_dirty) begin
        program_shadow();
      end
      return;
    end
    page = (addr - REG_SPACE) / PAGE_WORDS;
    word = (addr - REG_SPACE) % PAGE_WORDS;
    if (shadow_dirty && shadow_buf_page != page) program_shadow();
    if (page >= PAGE_COUNT) begin
      shadow_status = 3'b001;  // range error leaves everything else alone
      return;
    end
    if (!(shadow_buf_valid && shadow_buf_page == page)) begin
      foreach (shadow_buf[w]) shadow_buf[w] = shadow_array[page][w];
    end
    if (we) begin
      shadow_buf[word] = data;
      shadow_dirty     = 1'b1;
    end
    shadow_buf_valid = 1'b1;
    shadow_buf_page  = page;
    shadow_status    = 3'b000;
  endfunction

  function automatic logic [WB_DW-1:0] expect_read(input logic [WB_AW-1:0] addr);
    int page;
    int word;
    if (addr < REG_SPACE) begin
      case (addr[5:0])
        REG_FLASH_STATUS: return {13'b0, shadow_status};  // busy bit 8 must be clear
        REG_PAGE_STATUS:  return shadow_prog[shadow_status_page];
        REG_DIRTY_PAGE:   return shadow_dirty ? WB_DW'(shadow_buf_page) : 16'hffff;
        default:          return '0;
      endcase
    end
    page = (addr - REG_SPACE) / PAGE_WORDS;
    word = (addr - REG_SPACE) % PAGE_WORDS;
    if (shadow_buf_valid && shadow_buf_page == page) return shadow_buf[word];
    return shadow_array[page][word];
  endfunction

  // one classic cycle held until ack
  task automatic wb_access(input logic we, input logic [WB_AW-1:0] addr,
                           input logic [WB_DW-1:0] data);
    int   ack_cycles;
    logic reg_only;  // plain register access acks on the next cycle
    reg_only = (addr < REG_SPACE) &&
               !(!we && addr[5:0] == REG_PAGE_STATUS) &&
               !(we && addr[5:0] == REG_DIRTY_SYNC);
    ack_cycles = 0;
    @(posedge wb_clk);
    #1;
    wb_cyc    = 1'b1;
    wb_stb    = 1'b1;
    wb_we     = we;
    wb_adr    = addr;
    wb_wdat   = data;
    rd_active = !we;
    do begin
      @(posedge wb_clk);
      #1;
      ack_cycles++;
    end while (!wb_ack);
    wb_cyc = 1'b0;
    wb_stb = 1'b0;
    wb_we  = 1'b0;
    if (reg_only) begin
      if (ack_cycles != 1) begin
        $display("** Error wb_ack_o latency addr %h: expected %h, got %h",
                 addr, 32'd1, ack_cycles);
        fail_count++;
      end else begin
        pass_count++;
      end
    end
    @(posedge wb_clk);
    rd_active = 1'b0;
    #1;
    if (wb_ack) begin
      $display("ack for address %h stayed high for more than one cycle", addr);
      fail_count++;
    end
  endtask

  task automatic write_bus(input logic [WB_AW-1:0] addr, input logic [WB_DW-1:0] data);
    wb_access(1'b1, addr, data);
    update_shadow(1'b1, addr, data);
  endtask

  task automatic check_read(input logic [WB_AW-1:0] addr);
    exp_q.push_back(expect_read(addr));
    addr_q.push_back(addr);
    wb_access(1'b0, addr, '0);
    update_shadow(1'b0, addr, '0);
  endtask

  task automatic report_test(input string name);
    $display("%-26s %0d checks, %0d errors", name,
             pass_count + fail_count - pass_start - fail_start, fail_count - fail_start);
    pass_start = pass_count;
    fail_start = fail_count;
  endtask

  always @(negedge wb_clk) begin
    if (wb_ack && rd_active) begin
      if (exp_q.size() == 0) begin
        $display("read at address %h was acked with no expected value queued", wb_adr);
        fail_count++;
      end else begin
        exp_val  = exp_q.pop_front();
        exp_addr = addr_q.pop_front();
        if (wb_rdat !== exp_val) begin
          $display("** Error wb_dat_o addr %h: expected %h, got %h", exp_addr, exp_val, wb_rdat);
          fail_count++;
        end else begin
          pass_count++;
        end
      end
    end
  end

  initial begin
    repeat (WATCHDOG_CYCLES) @(posedge wb_clk);
    $display("watchdog expired after %0d cycles, the DUT stopped acking", WATCHDOG_CYCLES);
    $display("Verification failed");
    $finish;
  end

  initial begin
    void'($urandom(32'h29dbd85a));
    wb_cyc    = 1'b0;
    wb_stb    = 1'b0;
    wb_we     = 1'b0;
    wb_adr    = '0;
    wb_wdat   = '0;
    rd_active = 1'b0;
    {pass_count, fail_count, pass_start, fail_start} = '0;
    foreach (shadow_array[p, w]) shadow_array[p][w] = '0;
    foreach (shadow_prog[p]) shadow_prog[p] = '0;
    {shadow_buf_page, shadow_status_page, shadow_buf_valid, shadow_dirty} = '0;
    shadow_status = 3'b111;
    @(negedge wb_rst);

    check_read(ADR_STATUS);
    check_read(ADR_DIRTY);
    report_test("reset state");

    for (i = 0; i < T1_WRITES; i++) begin
      t1_addr[i] = word_address(3, $urandom_range(PAGE_WORDS - 1, 0));
      write_bus(t1_addr[i], WB_DW'($urandom));
    end
    for (i = 0; i < T1_WRITES; i++) check_read(t1_addr[i]);
    check_read(ADR_DIRTY);
    report_test("buffered write and read");

    write_bus(ADR_PSTAT, 16'd3);
    check_read(ADR_PSTAT);
    write_bus(word_address(7, $urandom_range(PAGE_WORDS - 1, 0)), WB_DW'($urandom));
    write_bus(ADR_PSTAT, 16'd3);
    check_read(ADR_PSTAT);  // page 3 programmed once by now
    for (i = 0; i < T2_READS; i++) check_read(t1_addr[i]);
    check_read(ADR_DIRTY);
    report_test("program before access");

    for (i = 0; i < T3_WRITES; i++) begin
      t3_addr[i] = word_address(9, $urandom_range(PAGE_WORDS - 1, 0));
      write_bus(t3_addr[i], WB_DW'($urandom));
    end
    write_bus(ADR_SYNC, '0);
    check_read(ADR_DIRTY);
    check_read(ADR_SYNC);
    check_read(ADR_STATUS);
    for (i = 0; i < T3_WRITES; i++) check_read(t3_addr[i]);
    write_bus(ADR_SYNC, '0);  // clean buffer
    report_test("sync");

    foreach (status_pages[k]) begin
      write_bus(ADR_PSTAT, WB_DW'(status_pages[k]));
      check_read(ADR_PSTAT);
    end
    report_test("page status");

    write_bus(ADR_SYNC, '0);
    write_bus(word_address($urandom_range(1000, PAGE_COUNT), $urandom_range(63, 0)),
              WB_DW'($urandom));
    check_read(ADR_STATUS);
    check_read(ADR_DIRTY);
    check_read(t3_addr[0]);
    check_read(ADR_STATUS);
    write_bus(word_address(PAGE_COUNT, 0), 16'hdead);
    check_read(ADR_STATUS);
    report_test("range error");

    if (exp_q.size() != 0) begin
      $display("%0d expected reads were never acked", exp_q.size());
      fail_count++;
    end
    $display("checks: %0d passed, %0d failed", pass_count, fail_count);
    if (fail_count == 0) begin
      $display("Verification passed");
    end else begin
      $display("Verification failed");
    end
    $finish;
  end

endmodule

// File: list.f
flash_ctrl_pkg.sv
flashmem_controller.sv
flash_emulator.sv
flash_subsystem.sv
tb_clock_gen.sv
tb_flash_subsystem.sv

// File: Bender.yml
package:
  name: flash_subsystem

sources:
  - flash_ctrl_pkg.sv
  - flashmem_controller.sv
  - flash_emulator.sv
  - flash_subsystem.sv
  - target: test
    files:
      - tb_clock_gen.sv
      - tb_flash_subsystem.sv
